//--- logic/fifo_pkg.sv
package fifo_pkg;

   // write side word and read side byte
   localparam int FIFO_W_DATA_W = 32;
   localparam int FIFO_R_DATA_W = 8;

   // byte address, 64 bytes of storage
   localparam int FIFO_ADDR_W = 6;

   // one bank per byte lane
   localparam int FIFO_LANES = FIFO_W_DATA_W / FIFO_R_DATA_W;

   // word address inside a bank
   localparam int FIFO_LANE_ADDR_W = FIFO_ADDR_W - $clog2(FIFO_LANES);

   // level counts bytes and must reach the full depth
   localparam int FIFO_LEVEL_W = FIFO_ADDR_W + 1;

   // write request to one bank
   typedef struct packed {
      logic                        en;
      logic [FIFO_LANE_ADDR_W-1:0] addr;
      logic [FIFO_R_DATA_W-1:0]    data;
   } lane_wr_t;

   // read request to one bank, data comes back a cycle later
   typedef struct packed {
      logic                        en;
      logic [FIFO_LANE_ADDR_W-1:0] addr;
   } lane_rd_t;

endpackage

//--- logic/ram_2p_bank.sv
`timescale 1ns/1ns

module ram_2p_bank #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic                clk_i,
   input  fifo_pkg::lane_wr_t  wr_i,
   input  fifo_pkg::lane_rd_t  rd_i,
   output logic [DATA_W-1:0]   rd_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   // storage of one byte lane
   logic [DATA_W-1:0] mem [DEPTH];

   // write port
   always_ff @(posedge clk_i) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // registered read, output holds between reads
   always_ff @(posedge clk_i) begin
      if (rd_i.en) begin
         rd_data_o <= mem[rd_i.addr];
      end
   end

   // the controller never reads a word while it writes the same word,
   // so read-during-write ordering does not matter here

endmodule

//--- logic/ram_2p_asym.sv
`timescale 1ns/1ns

module ram_2p_asym (
   input  logic                                                   clk_i,

   // wide write side
   input  logic                                                   w_en_i,
   input  logic [fifo_pkg::FIFO_LANE_ADDR_W-1:0]                  w_addr_i,
   input  logic [fifo_pkg::FIFO_W_DATA_W-1:0]                     w_data_i,

   // narrow read side
   input  logic                                                   r_en_i,
   input  logic [fifo_pkg::FIFO_ADDR_W-1:0]                       r_addr_i,
   output logic [fifo_pkg::FIFO_R_DATA_W-1:0]                     r_data_o,

   // byte lane banks
   output fifo_pkg::lane_wr_t [fifo_pkg::FIFO_LANES-1:0]          lane_wr_o,
   output fifo_pkg::lane_rd_t [fifo_pkg::FIFO_LANES-1:0]          lane_rd_o,
   input  logic [fifo_pkg::FIFO_LANES-1:0][fifo_pkg::FIFO_R_DATA_W-1:0] lane_data_i
);

   localparam int LANES   = fifo_pkg::FIFO_LANES;
   localparam int BYTE_W  = fifo_pkg::FIFO_R_DATA_W;
   localparam int ADDR_W  = fifo_pkg::FIFO_ADDR_W;
   localparam int SEL_W   = $clog2(LANES);

   // lane of the byte in flight
   logic [SEL_W-1:0] r_sel_q;

   genvar k;
   generate
      for (k = 0; k < LANES; k++) begin : g_lane
         // word write goes to every lane, byte k to lane k
         assign lane_wr_o[k].en   = w_en_i;
         assign lane_wr_o[k].addr = w_addr_i;
         assign lane_wr_o[k].data = w_data_i[k*BYTE_W +: BYTE_W];

         // all lanes read the same word
         assign lane_rd_o[k].en   = r_en_i;
         assign lane_rd_o[k].addr = r_addr_i[ADDR_W-1:SEL_W];
      end
   endgenerate

   // remember which byte was asked for until the bank answers
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_sel_q <= r_addr_i[SEL_W-1:0];
      end
   end

   // banks and r_sel_q both hold between reads, so the byte holds too
   assign r_data_o = lane_data_i[r_sel_q];

   // a word is never read in the cycle it is written
   a_no_collide: assert property (
      @(posedge clk_i)
      (w_en_i && r_en_i) |-> (w_addr_i != r_addr_i[ADDR_W-1:SEL_W])
   ) else $error("read and write hit the same word");

endmodule

//--- logic/fifo_sync_asym.sv
`timescale 1ns/1ns

module fifo_sync_asym (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  clk_en_i,
   input  logic                                  flush_i,

   // write side
   input  logic                                  w_en_i,
   input  logic [fifo_pkg::FIFO_W_DATA_W-1:0]    w_data_i,
   output logic                                  w_full_o,

   // read side
   input  logic                                  r_en_i,
   output logic [fifo_pkg::FIFO_R_DATA_W-1:0]    r_data_o,
   output logic                                  r_empty_o,

   // stored bytes
   output logic [fifo_pkg::FIFO_LEVEL_W-1:0]     level_o,

   // memory side
   output logic                                  mem_w_en_o,
   output logic [fifo_pkg::FIFO_LANE_ADDR_W-1:0] mem_w_addr_o,
   output logic [fifo_pkg::FIFO_W_DATA_W-1:0]    mem_w_data_o,
   output logic                                  mem_r_en_o,
   output logic [fifo_pkg::FIFO_ADDR_W-1:0]      mem_r_addr_o,
   input  logic [fifo_pkg::FIFO_R_DATA_W-1:0]    mem_r_data_i
);

   localparam int LEVEL_W = fifo_pkg::FIFO_LEVEL_W;
   localparam int SEL_W   = $clog2(fifo_pkg::FIFO_LANES);

   // sizes in bytes
   localparam logic [LEVEL_W-1:0] FIFO_SIZE   = LEVEL_W'(1 << fifo_pkg::FIFO_ADDR_W);
   localparam logic [LEVEL_W-1:0] W_INCR      = LEVEL_W'(fifo_pkg::FIFO_LANES);
   localparam logic [LEVEL_W-1:0] R_INCR      = LEVEL_W'(1);
   localparam logic [LEVEL_W-1:0] FULL_THRESH = FIFO_SIZE - W_INCR;

   // write pointer counts words, read pointer counts bytes
   logic [fifo_pkg::FIFO_LANE_ADDR_W-1:0] w_ptr_q;
   logic [fifo_pkg::FIFO_ADDR_W-1:0]      r_ptr_q;

   logic [LEVEL_W-1:0] level_q;
   logic [LEVEL_W-1:0] level_nxt;
   logic               empty_q;
   logic               full_q;

   // accepted operations
   logic w_acc;
   logic r_acc;

   // flush wins over both strobes; clk_en_i gates the banks as well
   assign w_acc = clk_en_i & w_en_i & ~full_q & ~flush_i;
   assign r_acc = clk_en_i & r_en_i & ~empty_q & ~flush_i;

   always_comb begin
      level_nxt = level_q;
      if (flush_i) begin
         level_nxt = '0;
      end else begin
         if (w_acc) begin
            level_nxt = level_nxt + W_INCR;
         end
         if (r_acc) begin
            level_nxt = level_nxt - R_INCR;
         end
      end
   end

   // pointers wrap naturally
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
      end else if (clk_en_i) begin
         if (flush_i) begin
            w_ptr_q <= '0;
            r_ptr_q <= '0;
         end else begin
            if (w_acc) begin
               w_ptr_q <= w_ptr_q + 1'b1;
            end
            if (r_acc) begin
               r_ptr_q <= r_ptr_q + 1'b1;
            end
         end
      end
   end

   // level and flags, all from the same next level
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         level_q <= '0;
         empty_q <= 1'b1;
         full_q  <= 1'b0;
      end else if (clk_en_i) begin
         level_q <= level_nxt;
         empty_q <= (level_nxt == '0);
         // full once a whole word no longer fits
         full_q  <= (level_nxt > FULL_THRESH);
      end
   end

   assign mem_w_en_o   = w_acc;
   assign mem_w_addr_o = w_ptr_q;
   assign mem_w_data_o = w_data_i;
   assign mem_r_en_o   = r_acc;
   assign mem_r_addr_o = r_ptr_q;

   // byte arrives one cycle after the read
   assign r_data_o  = mem_r_data_i;
   assign level_o   = level_q;
   assign w_full_o  = full_q;
   assign r_empty_o = empty_q;

   a_level_max: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      level_q <= FIFO_SIZE
   ) else $error("level above FIFO size");

   // stored bytes match the distance between the pointers
   a_ptr_level: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      level_q[fifo_pkg::FIFO_ADDR_W-1:0] == ({w_ptr_q, {SEL_W{1'b0}}} - r_ptr_q)
   ) else $error("level does not match the pointer distance");

endmodule

//--- logic/fifo_sync_top.sv
`timescale 1ns/1ns

module fifo_sync_top (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  logic                               clk_en_i,
   input  logic                               flush_i,
   input  logic                               w_en_i,
   input  logic [fifo_pkg::FIFO_W_DATA_W-1:0] w_data_i,
   output logic                               w_full_o,
   input  logic                               r_en_i,
   output logic [fifo_pkg::FIFO_R_DATA_W-1:0] r_data_o,
   output logic                               r_empty_o,
   output logic [fifo_pkg::FIFO_LEVEL_W-1:0]  level_o
);

   logic                                  mem_w_en;
   logic [fifo_pkg::FIFO_LANE_ADDR_W-1:0] mem_w_addr;
   logic [fifo_pkg::FIFO_W_DATA_W-1:0]    mem_w_data;
   logic                                  mem_r_en;
   logic [fifo_pkg::FIFO_ADDR_W-1:0]      mem_r_addr;
   logic [fifo_pkg::FIFO_R_DATA_W-1:0]    mem_r_data;

   fifo_pkg::lane_wr_t [fifo_pkg::FIFO_LANES-1:0]                 lane_wr;
   fifo_pkg::lane_rd_t [fifo_pkg::FIFO_LANES-1:0]                 lane_rd;
   logic [fifo_pkg::FIFO_LANES-1:0][fifo_pkg::FIFO_R_DATA_W-1:0] lane_data;

   fifo_sync_asym u_ctrl (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .clk_en_i     (clk_en_i),
      .flush_i      (flush_i),
      .w_en_i       (w_en_i),
      .w_data_i     (w_data_i),
      .w_full_o     (w_full_o),
      .r_en_i       (r_en_i),
      .r_data_o     (r_data_o),
      .r_empty_o    (r_empty_o),
      .level_o      (level_o),
      .mem_w_en_o   (mem_w_en),
      .mem_w_addr_o (mem_w_addr),
      .mem_w_data_o (mem_w_data),
      .mem_r_en_o   (mem_r_en),
      .mem_r_addr_o (mem_r_addr),
      .mem_r_data_i (mem_r_data)
   );

   ram_2p_asym u_adapt (
      .clk_i       (clk_i),
      .w_en_i      (mem_w_en),
      .w_addr_i    (mem_w_addr),
      .w_data_i    (mem_w_data),
      .r_en_i      (mem_r_en),
      .r_addr_i    (mem_r_addr),
      .r_data_o    (mem_r_data),
      .lane_wr_o   (lane_wr),
      .lane_rd_o   (lane_rd),
      .lane_data_i (lane_data)
   );

   // one bank per byte lane
   for (genvar g = 0; g < fifo_pkg::FIFO_LANES; g++) begin : g_bank
      ram_2p_bank #(
         .DATA_W (fifo_pkg::FIFO_R_DATA_W),
         .ADDR_W (fifo_pkg::FIFO_LANE_ADDR_W)
      ) u_bank (
         .clk_i     (clk_i),
         .wr_i      (lane_wr[g]),
         .rd_i      (lane_rd[g]),
         .rd_data_o (lane_data[g])
      );
   end

endmodule

//--- verif/tb_fifo_sync.sv
`timescale 1ns/1ns

module tb_fifo_sync;

   localparam int W_W   = fifo_pkg::FIFO_W_DATA_W;
   localparam int R_W   = fifo_pkg::FIFO_R_DATA_W;
   localparam int LVL_W = fifo_pkg::FIFO_LEVEL_W;
   localparam int LANES = fifo_pkg::FIFO_LANES;
   // storage in bytes
   localparam int DEPTH       = 1 << fifo_pkg::FIFO_ADDR_W;
   localparam int RESET_LIMIT = 20;
   localparam int DRAIN_LIMIT = 2 * DEPTH;

   typedef enum logic [2:0] {OP_IDLE, OP_WR, OP_RD, OP_BOTH, OP_FLUSH, OP_STALL} op_e;

   typedef struct packed {
      op_e            op;
      logic [W_W-1:0] data;
   } step_t;

   logic             clk;
   logic             rst_n;
   logic             clk_en;
   logic             flush;
   logic             w_en;
   logic [W_W-1:0]   w_data;
   logic             w_full;
   logic             r_en;
   logic [R_W-1:0]   r_data;
   logic             r_empty;
   logic [LVL_W-1:0] level;

   // stimulus table and reference model
   step_t          steps[$];
   logic [R_W-1:0] model_q[$];
   logic           exp_empty;
   logic           exp_full;
   logic [R_W-1:0] exp_rdata;
   logic           rdata_known;
   int             mismatch_cnt;
   int             timeout_cnt;

   fifo_sync_top uut (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .clk_en_i  (clk_en),
      .flush_i   (flush),
      .w_en_i    (w_en),
      .w_data_i  (w_data),
      .w_full_o  (w_full),
      .r_en_i    (r_en),
      .r_data_o  (r_data),
      .r_empty_o (r_empty),
      .level_o   (level)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   task automatic add_steps(input op_e op, input int n);
      step_t s;
      for (int i = 0; i < n; i++) begin
         s.op   = op;
         s.data = $urandom;
         steps.push_back(s);
      end
   endtask

   task automatic build_table();
      // one word out as four bytes
      add_steps(OP_WR, 1);
      add_steps(OP_RD, 4);
      add_steps(OP_IDLE, 1);
      // fill up, then two refused writes
      add_steps(OP_WR, DEPTH / LANES);
      add_steps(OP_WR, 2);
      // empty it, then two reads with nothing stored
      add_steps(OP_RD, DEPTH);
      add_steps(OP_RD, 2);
      // both strobes together, pointers wrap
      add_steps(OP_BOTH, 24);
      // clock enable low holds everything
      add_steps(OP_STALL, 2);
      add_steps(OP_RD, 8);
      add_steps(OP_FLUSH, 1);
      add_steps(OP_IDLE, 1);
      add_steps(OP_WR, 1);
      add_steps(OP_RD, 4);
      add_steps(OP_IDLE, 1);
   endtask

   task automatic drive(input step_t s);
      // a stall keeps both strobes up
      clk_en = (s.op != OP_STALL);
      w_en   = (s.op == OP_WR) || (s.op == OP_BOTH) || (s.op == OP_STALL);
      r_en   = (s.op == OP_RD) || (s.op == OP_BOTH) || (s.op == OP_STALL);
      flush  = (s.op == OP_FLUSH);
      w_data = s.data;
   endtask

   // what one edge does to the model
   task automatic model_edge(input step_t s);
      logic w_ok;
      logic r_ok;
      w_ok = ((s.op == OP_WR) || (s.op == OP_BOTH)) && !exp_full;
      r_ok = ((s.op == OP_RD) || (s.op == OP_BOTH)) && !exp_empty;
      if (s.op == OP_FLUSH) begin
         model_q.delete();
      end else begin
         if (r_ok) begin
            exp_rdata   = model_q.pop_front();
            rdata_known = 1'b1;
         end
         if (w_ok) begin
            // lowest byte leaves first
            for (int k = 0; k < LANES; k++) begin
               model_q.push_back(s.data[k*R_W +: R_W]);
            end
         end
      end
      exp_empty = (model_q.size() == 0);
      exp_full  = (model_q.size() > DEPTH - LANES);
   endtask

   task automatic check_outputs();
      logic [LVL_W-1:0] exp_level;
      exp_level = LVL_W'(model_q.size());
      assert (level === exp_level) else begin
         mismatch_cnt++;
         $display("MISMATCH at %0t ns: level_o is %0d, expected %0d", $time, level, exp_level);
      end
      assert (r_empty === exp_empty) else begin
         mismatch_cnt++;
         $display("MISMATCH at %0t ns: r_empty_o is %b, expected %b", $time, r_empty, exp_empty);
      end
      assert (w_full === exp_full) else begin
         mismatch_cnt++;
         $display("MISMATCH at %0t ns: w_full_o is %b, expected %b", $time, w_full, exp_full);
      end
      // no byte to compare before the first read
      if (rdata_known) begin
         assert (r_data === exp_rdata) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: r_data_o is %h, expected %h",
                     $time, r_data, exp_rdata);
         end
      end
   endtask

   // entered 5 ns after a rising edge, leaves 5 ns after the next one
   task automatic run_step(input step_t s);
      drive(s);
      @(posedge clk);
      model_edge(s);
      #2;
      check_outputs();
      #3;
   endtask

   task automatic wait_empty(input int limit, output logic ok);
      int n;
      n = 0;
      while (r_empty !== 1'b1 && n < limit) begin
         @(posedge clk);
         n++;
      end
      ok = (r_empty === 1'b1);
      if (!ok) begin
         timeout_cnt++;
         $display("timeout: r_empty_o did not rise within %0d cycles after reset", limit);
      end
   endtask

   // read until the DUT says empty
   task automatic drain(input int limit);
      step_t s;
      int    n;
      s.op   = OP_RD;
      s.data = '0;
      n      = 0;
      while (r_empty !== 1'b1 && n < limit) begin
         run_step(s);
         n++;
      end
      if (r_empty !== 1'b1) begin
         timeout_cnt++;
         $display("timeout: FIFO did not drain within %0d reads", limit);
      end
      s.op = OP_IDLE;
      run_step(s);
   endtask

   task automatic report();
      $display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
      if (mismatch_cnt == 0 && timeout_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   endtask

   initial begin
      logic ok;
      rst_n        = 1'b0;
      clk_en       = 1'b1;
      flush        = 1'b0;
      w_en         = 1'b0;
      w_data       = '0;
      r_en         = 1'b0;
      exp_empty    = 1'b1;
      exp_full     = 1'b0;
      exp_rdata    = '0;
      rdata_known  = 1'b0;
      mismatch_cnt = 0;
      timeout_cnt  = 0;
      void'($urandom(32'h39b2_4ae3));
      build_table();

      repeat (10) @(posedge clk);
      #5;
      rst_n = 1'b1;

      wait_empty(RESET_LIMIT, ok);
      if (ok) begin
         // state straight after reset
         @(posedge clk);
         #2;
         check_outputs();
         #3;
         foreach (steps[i]) begin
            run_step(steps[i]);
         end
         drain(DRAIN_LIMIT);
      end
      report();
   end

endmodule

//--- filelist.f
logic/fifo_pkg.sv
logic/ram_2p_bank.sv
logic/ram_2p_asym.sv
logic/fifo_sync_asym.sv
logic/fifo_sync_top.sv
verif/tb_fifo_sync.sv

//--- run_sim.sh
#!/bin/sh
# build and run the FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_fifo_sync
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module "$TOP" -o "V$TOP"
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
   echo "no result line found in $LOG"
   exit 1
fi
exit 0
